/* common/video_mode_pkg.sv */
package video_mode_pkg;

	////////////////////////////////////////////////////////////
	// Switch codes and shared widths
	////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		FMT_VGA    = 4'b0000, // 640x480
		FMT_SVGA   = 4'b0001, // 800x600
		FMT_HD720P = 4'b0010, // 1280x720
		FMT_XGA    = 4'b0011, // 1024x768
		FMT_SXGA   = 4'b1000, // 1280x1024
		FMT_CAMERA = 4'b1001  // 1280x720, trimmed porches
	} fmt_e;

	typedef logic [10:0] coord_t;     // Pixel or line count
	typedef logic [7:0]  synth_div_t; // Synthesizer M or D, minus one

	////////////////////////////////////////////////////////////
	// Raster timing per format
	////////////////////////////////////////////////////////////

	// Slot order inside each timing array
	localparam int T_ACT  = 0; // Active size
	localparam int T_FP   = 1; // Front porch
	localparam int T_SYNC = 2; // Sync width
	localparam int T_BP   = 3; // Back porch

	localparam coord_t VGA_H [4] = '{11'd640, 11'd16, 11'd96, 11'd48};
	localparam coord_t VGA_V [4] = '{11'd480, 11'd11, 11'd2, 11'd31};

	localparam coord_t SVGA_H [4] = '{11'd800, 11'd40, 11'd128, 11'd88};
	localparam coord_t SVGA_V [4] = '{11'd600, 11'd1, 11'd4, 11'd23};

	localparam coord_t XGA_H [4] = '{11'd1024, 11'd24, 11'd136, 11'd160};
	localparam coord_t XGA_V [4] = '{11'd768, 11'd3, 11'd6, 11'd29};

	localparam coord_t HD720P_H [4] = '{11'd1280, 11'd110, 11'd40, 11'd220};
	localparam coord_t HD720P_V [4] = '{11'd720, 11'd5, 11'd5, 11'd20};

	localparam coord_t SXGA_H [4] = '{11'd1280, 11'd48, 11'd112, 11'd248};
	localparam coord_t SXGA_V [4] = '{11'd1024, 11'd1, 11'd3, 11'd38};

	// Camera variant of 720p
	localparam coord_t CAMERA_H [4] = '{11'd1280, 11'd110, 11'd39, 11'd220};
	localparam coord_t CAMERA_V [4] = '{11'd720, 11'd4, 11'd4, 11'd22};

	// Sync polarity, 1 means active low
	localparam logic NEG_VGA    = 1'b1;
	localparam logic NEG_SVGA   = 1'b0;
	localparam logic NEG_XGA    = 1'b1;
	localparam logic NEG_HD720P = 1'b0;
	localparam logic NEG_SXGA   = 1'b0;
	localparam logic NEG_CAMERA = 1'b0;

	////////////////////////////////////////////////////////////
	// Pixel-clock synthesizer ratios off the 50 MHz clock
	////////////////////////////////////////////////////////////

	localparam synth_div_t PCLK_M_VGA = 8'd2 - 8'd1;   // 25 MHz
	localparam synth_div_t PCLK_D_VGA = 8'd4 - 8'd1;
	localparam synth_div_t PCLK_M_SVGA = 8'd4 - 8'd1;  // 40 MHz
	localparam synth_div_t PCLK_D_SVGA = 8'd5 - 8'd1;
	localparam synth_div_t PCLK_M_XGA = 8'd13 - 8'd1;  // 65 MHz
	localparam synth_div_t PCLK_D_XGA = 8'd10 - 8'd1;
	localparam synth_div_t PCLK_M_SXGA = 8'd54 - 8'd1; // 108 MHz
	localparam synth_div_t PCLK_D_SXGA = 8'd25 - 8'd1;
	localparam synth_div_t PCLK_M_CAMERA = 8'd135 - 8'd1; // Just under 74.25 MHz
	localparam synth_div_t PCLK_D_CAMERA = 8'd91 - 8'd1;
	localparam synth_div_t PCLK_M_DEF = 8'd248 - 8'd1; // 74.25 MHz, 720p and unlisted codes
	localparam synth_div_t PCLK_D_DEF = 8'd167 - 8'd1;

endpackage

/* hw/mode_ctrl.sv */
`timescale 1ns/1ps

module mode_ctrl #(
	parameter int SETTLE_CYCLES = 1024
) (
	input  logic                       clk50m_bufg,
	input  logic                       RSTBTN,
	input  logic [3:0]                 sw_stable,
	input  logic                       sw_changed,
	output video_mode_pkg::fmt_e       fmt,     // Format in use
	output video_mode_pkg::synth_div_t pclk_m,  // Synth multiply, minus one
	output video_mode_pkg::synth_div_t pclk_d,  // Synth divide, minus one
	output logic                       prog_go, // Program the synth
	output logic                       restart  // Hold the raster
);

	localparam int CNT_W = (SETTLE_CYCLES > 1) ? $clog2(SETTLE_CYCLES) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SETTLE_CYCLES - 1);

	typedef enum logic [1:0] {
		ST_LOAD,   // Take the format, send go
		ST_SETTLE, // Wait in place of the synth lock
		ST_RUN     // Raster free running
	} state_e;

	state_e                     state;
	logic [CNT_W-1:0]           settle_cnt;
	logic                       load;
	video_mode_pkg::synth_div_t m_sel;
	video_mode_pkg::synth_div_t d_sel;

	// First pass after reset, or any new switch value, even mid settle
	assign load = (state == ST_LOAD) || sw_changed;

	////////////////////////////////////////////////////////////
	// M/D lookup
	////////////////////////////////////////////////////////////

	always_comb begin
		case (sw_stable)
			video_mode_pkg::FMT_VGA: begin
				m_sel = video_mode_pkg::PCLK_M_VGA;
				d_sel = video_mode_pkg::PCLK_D_VGA;
			end
			video_mode_pkg::FMT_SVGA: begin
				m_sel = video_mode_pkg::PCLK_M_SVGA;
				d_sel = video_mode_pkg::PCLK_D_SVGA;
			end
			video_mode_pkg::FMT_XGA: begin
				m_sel = video_mode_pkg::PCLK_M_XGA;
				d_sel = video_mode_pkg::PCLK_D_XGA;
			end
			video_mode_pkg::FMT_SXGA: begin
				m_sel = video_mode_pkg::PCLK_M_SXGA;
				d_sel = video_mode_pkg::PCLK_D_SXGA;
			end
			video_mode_pkg::FMT_CAMERA: begin
				m_sel = video_mode_pkg::PCLK_M_CAMERA;
				d_sel = video_mode_pkg::PCLK_D_CAMERA;
			end
			default: begin // 720p and every unlisted code
				m_sel = video_mode_pkg::PCLK_M_DEF;
				d_sel = video_mode_pkg::PCLK_D_DEF;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// Control FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			state      <= ST_LOAD;
			fmt        <= video_mode_pkg::FMT_VGA;
			pclk_m     <= video_mode_pkg::PCLK_M_VGA;
			pclk_d     <= video_mode_pkg::PCLK_D_VGA;
			prog_go    <= 1'b0;
			restart    <= 1'b1; // Raster held until settled
			settle_cnt <= '0;
		end else begin
			prog_go <= 1'b0;
			if (load) begin
				state      <= ST_SETTLE;
				fmt        <= video_mode_pkg::fmt_e'(sw_stable);
				pclk_m     <= m_sel;
				pclk_d     <= d_sel;
				prog_go    <= 1'b1;
				restart    <= 1'b1;
				settle_cnt <= '0;
			end else if (state == ST_SETTLE) begin
				if (settle_cnt == CNT_LAST) begin
					state   <= ST_RUN;
					restart <= 1'b0; // Let the raster go
				end else begin
					settle_cnt <= settle_cnt + 1'b1;
				end
			end
		end
	end

	// Go only as the settle wait begins
	a_go_on_entry: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		prog_go |-> (state == ST_SETTLE) && ($past(state) != ST_SETTLE || $past(sw_changed)));

endmodule

/* hw/switch_filter.sv */
`timescale 1ns/1ps

module switch_filter #(
	parameter int DEBOUNCE_CYCLES = 65536
) (
	input  logic       clk50m_bufg,
	input  logic       RSTBTN,
	input  logic [3:0] sw,         // Raw slide switches
	output logic [3:0] sw_stable,  // Debounced value
	output logic       sw_changed  // One cycle, with each new sw_stable
);

	localparam int CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

	logic [3:0]       sw_meta;  // First synchronizer stage
	logic [3:0]       sw_sync;  // Second stage, safe to use
	logic [CNT_W-1:0] deb_cnt;  // Cycles since the last move
	logic             moved;
	logic             expire;

	// Value about to move in the synchronizer
	assign moved = (sw_meta != sw_sync);

	// Quiet long enough and different from what is held
	assign expire = !moved && (deb_cnt == CNT_LAST) && (sw_sync != sw_stable);

	////////////////////////////////////////////////////////////
	// Synchronizer and shared debounce counter
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			sw_meta <= 4'b0000;
			sw_sync <= 4'b0000;
			deb_cnt <= '0;
		end else begin
			sw_meta <= sw;
			sw_sync <= sw_meta;
			if (moved)
				deb_cnt <= '0;             // Any bit moved, start over
			else if (deb_cnt != CNT_LAST)
				deb_cnt <= deb_cnt + 1'b1; // Saturates at the last count
		end
	end

	// Hand over the settled value
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			sw_stable  <= 4'b0000;
			sw_changed <= 1'b0;
		end else begin
			sw_changed <= expire;
			if (expire)
				sw_stable <= sw_sync;
		end
	end

	// A change is a single strobe for the mode controller
	a_changed_single: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		sw_changed |=> !sw_changed);

endmodule

/* hw/video_mode_top.sv */
`timescale 1ns/1ps

module video_mode_top #(
	parameter int DEBOUNCE_CYCLES = 1 << 16, // Switch quiet time in clocks
	parameter int SETTLE_CYCLES   = 1024     // Stand-in for the synth lock
) (
	input  logic                       clk50m_bufg,
	input  logic                       RSTBTN,
	input  logic [3:0]                 sw,
	output video_mode_pkg::fmt_e       fmt,
	output video_mode_pkg::synth_div_t pclk_m,
	output video_mode_pkg::synth_div_t pclk_d,
	output logic                       prog_go,
	output video_mode_pkg::coord_t     hcount,
	output video_mode_pkg::coord_t     vcount,
	output logic                       hsync,
	output logic                       vsync,
	output logic                       de
);

	logic [3:0]             sw_stable;
	logic                   sw_changed;
	logic                   restart;
	video_mode_pkg::coord_t h_sblnk;
	video_mode_pkg::coord_t h_ssync;
	video_mode_pkg::coord_t h_esync;
	video_mode_pkg::coord_t h_eblnk;
	video_mode_pkg::coord_t v_sblnk;
	video_mode_pkg::coord_t v_ssync;
	video_mode_pkg::coord_t v_esync;
	video_mode_pkg::coord_t v_eblnk;
	logic                   sync_neg;

	// Switches in
	switch_filter #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) u_switch_filter (
		.clk50m_bufg(clk50m_bufg),
		.RSTBTN     (RSTBTN),
		.sw         (sw),
		.sw_stable  (sw_stable),
		.sw_changed (sw_changed)
	);

	// Format, synth ratio and restart
	mode_ctrl #(
		.SETTLE_CYCLES(SETTLE_CYCLES)
	) u_mode_ctrl (
		.clk50m_bufg(clk50m_bufg),
		.RSTBTN     (RSTBTN),
		.sw_stable  (sw_stable),
		.sw_changed (sw_changed),
		.fmt        (fmt),
		.pclk_m     (pclk_m),
		.pclk_d     (pclk_d),
		.prog_go    (prog_go),
		.restart    (restart)
	);

	timing_table u_timing_table (
		.fmt     (fmt),
		.h_sblnk (h_sblnk),
		.h_ssync (h_ssync),
		.h_esync (h_esync),
		.h_eblnk (h_eblnk),
		.v_sblnk (v_sblnk),
		.v_ssync (v_ssync),
		.v_esync (v_esync),
		.v_eblnk (v_eblnk),
		.sync_neg(sync_neg)
	);

	// Raster out
	raster_gen u_raster_gen (
		.clk50m_bufg(clk50m_bufg),
		.restart    (restart),
		.h_sblnk    (h_sblnk),
		.h_ssync    (h_ssync),
		.h_esync    (h_esync),
		.h_eblnk    (h_eblnk),
		.v_sblnk    (v_sblnk),
		.v_ssync    (v_ssync),
		.v_esync    (v_esync),
		.v_eblnk    (v_eblnk),
		.sync_neg   (sync_neg),
		.hcount     (hcount),
		.vcount     (vcount),
		.hsync      (hsync),
		.vsync      (vsync),
		.de         (de)
	);

endmodule

/* list.f */
+incdir+verif
common/video_mode_pkg.sv
hw/switch_filter.sv
hw/mode_ctrl.sv
video/timing_table.sv
video/raster_gen.sv
hw/video_mode_top.sv
verif/tb_video_mode.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the video mode testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -j 0 --top-module tb_video_mode -f list.f

./obj_dir/Vtb_video_mode | tee sim.log

if grep -q ">>> FAIL" sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
	echo "Simulation ended without a verdict"
	exit 1
fi
echo "Simulation passed"

/* verif/tb_ref.svh */
`ifndef TB_REF_SVH
`define TB_REF_SVH

////////////////////////////////////////////////////////////
// Reference video timing, porch numbers per switch code
////////////////////////////////////////////////////////////

// Horizontal terms: 0 active, 1 front porch, 2 sync, 3 back porch
function automatic int h_part(input logic [3:0] code, input int idx);
	int p [4];
	case (code)
		4'h0:    p = '{640, 16, 96, 48};
		4'h1:    p = '{800, 40, 128, 88};
		4'h3:    p = '{1024, 24, 136, 160};
		4'h8:    p = '{1280, 48, 112, 248};
		4'h9:    p = '{1280, 110, 39, 220}; // Camera 720p
		default: p = '{1280, 110, 40, 220}; // 720p and unlisted codes
	endcase
	return p[idx];
endfunction

// Vertical terms, same order
function automatic int v_part(input logic [3:0] code, input int idx);
	int p [4];
	case (code)
		4'h0:    p = '{480, 11, 2, 31};
		4'h1:    p = '{600, 1, 4, 23};
		4'h3:    p = '{768, 3, 6, 29};
		4'h8:    p = '{1024, 1, 3, 38};
		4'h9:    p = '{720, 4, 4, 22};
		default: p = '{720, 5, 5, 20};
	endcase
	return p[idx];
endfunction

function automatic int line_length(input logic [3:0] code);
	return h_part(code, 0) + h_part(code, 1) + h_part(code, 2) + h_part(code, 3);
endfunction

function automatic int frame_lines(input logic [3:0] code);
	return v_part(code, 0) + v_part(code, 1) + v_part(code, 2) + v_part(code, 3);
endfunction

// Negative syncs only on VGA and XGA
function automatic logic sync_active_low(input logic [3:0] code);
	return (code == 4'h0) || (code == 4'h3);
endfunction

////////////////////////////////////////////////////////////
// Synth ratio, sent as the term minus one
////////////////////////////////////////////////////////////

function automatic video_mode_pkg::synth_div_t synth_m(input logic [3:0] code);
	int m;
	case (code)
		4'h0:    m = 2;
		4'h1:    m = 4;
		4'h3:    m = 13;
		4'h8:    m = 54;
		4'h9:    m = 135;
		default: m = 248;
	endcase
	return video_mode_pkg::synth_div_t'(m - 1);
endfunction

function automatic video_mode_pkg::synth_div_t synth_d(input logic [3:0] code);
	int d;
	case (code)
		4'h0:    d = 4;
		4'h1:    d = 5;
		4'h3:    d = 10;
		4'h8:    d = 25;
		4'h9:    d = 91;
		default: d = 167;
	endcase
	return video_mode_pkg::synth_div_t'(d - 1);
endfunction

////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////

task automatic check_fmt(input video_mode_pkg::fmt_e got, input video_mode_pkg::fmt_e exp,
		input string what);
	check_cnt++;
	if (got !== exp) begin
		err_cnt++;
		$display("[ERROR] %0t ns: %s: got %h, expected %h", $time, what, got, exp);
	end
endtask

task automatic check_div(input video_mode_pkg::synth_div_t got,
		input video_mode_pkg::synth_div_t exp, input string what);
	check_cnt++;
	if (got !== exp) begin
		err_cnt++;
		$display("[ERROR] %0t ns: %s: got %0d, expected %0d", $time, what, got, exp);
	end
endtask

task automatic check_count(input video_mode_pkg::coord_t got, input video_mode_pkg::coord_t exp,
		input string what);
	check_cnt++;
	if (got !== exp) begin
		err_cnt++;
		$display("[ERROR] %0t ns: %s: got %0d, expected %0d", $time, what, got, exp);
	end
endtask

// Plain cycle or pulse totals, wider than a coordinate
task automatic check_cycles(input int got, input int exp, input string what);
	check_cnt++;
	if (got != exp) begin
		err_cnt++;
		$display("[ERROR] %0t ns: %s: got %0d, expected %0d", $time, what, got, exp);
	end
endtask

task automatic check_level(input logic got, input logic exp, input string what);
	check_cnt++;
	if (got !== exp) begin
		err_cnt++;
		$display("[ERROR] %0t ns: %s: got %b, expected %b", $time, what, got, exp);
	end
endtask

`endif

/* verif/tb_video_mode.sv */
`timescale 1ns/1ps

module tb_video_mode;

	localparam int SIG_HS = 0; // Selectors for wait_for
	localparam int SIG_VS = 1;
	localparam int SIG_DE = 2;
	localparam int SIG_GO = 3;
	localparam int MAX_CYCLES = 2000000; // Whole run

	logic                       clk50m_bufg;
	logic                       RSTBTN;
	logic [3:0]                 sw;
	video_mode_pkg::fmt_e       fmt;
	video_mode_pkg::synth_div_t pclk_m;
	video_mode_pkg::synth_div_t pclk_d;
	logic                       prog_go;
	video_mode_pkg::coord_t     hcount;
	video_mode_pkg::coord_t     vcount;
	logic                       hsync;
	logic                       vsync;
	logic                       de;

	int         err_cnt = 0;
	int         check_cnt = 0;
	int         go_cnt = 0;    // prog_go pulses seen
	logic [3:0] exp_code;      // Code the next go should carry
	bit         hung = 1'b0;   // A wait ran out

	`include "tb_ref.svh"

	video_mode_top #(
		.DEBOUNCE_CYCLES(16),
		.SETTLE_CYCLES  (32)
	) UUT (
		.clk50m_bufg(clk50m_bufg),
		.RSTBTN     (RSTBTN),
		.sw         (sw),
		.fmt        (fmt),
		.pclk_m     (pclk_m),
		.pclk_d     (pclk_d),
		.prog_go    (prog_go),
		.hcount     (hcount),
		.vcount     (vcount),
		.hsync      (hsync),
		.vsync      (vsync),
		.de         (de)
	);

	initial begin
		clk50m_bufg = 1'b0;
		forever #10 clk50m_bufg = ~clk50m_bufg; // 50 MHz
	end

	// Every go must carry the expected format and ratio
	always @(negedge clk50m_bufg) begin
		if (prog_go) begin
			go_cnt++;
			check_fmt(fmt, video_mode_pkg::fmt_e'(exp_code), "fmt at prog_go");
			check_div(pclk_m, synth_m(exp_code), "pclk_m at prog_go");
			check_div(pclk_d, synth_d(exp_code), "pclk_d at prog_go");
		end
	end

	function automatic int unsigned lcg_next(input int unsigned s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic sig_value(input int sel);
		case (sel)
			SIG_HS:  return hsync;
			SIG_VS:  return vsync;
			SIG_DE:  return de;
			default: return prog_go;
		endcase
	endfunction

	function automatic string sig_name(input int sel);
		case (sel)
			SIG_HS:  return "hsync";
			SIG_VS:  return "vsync";
			SIG_DE:  return "de";
			default: return "prog_go";
		endcase
	endfunction

	// Drive and sample point, 2 ns past the edge
	task automatic tick();
		@(posedge clk50m_bufg);
		#2;
	endtask

	task automatic report_counts();
		$display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
	endtask

	task automatic note_timeout(input string what);
		$display("Timed out waiting for %s at %0t ns", what, $time);
		hung = 1'b1;
		repeat (2) @(posedge clk50m_bufg); // Watchdog stops the run
	endtask

	// n returns the cycles spent before the level showed up
	task automatic wait_for(input int sel, input logic level, input int limit, output int n);
		n = 0;
		while (sig_value(sel) !== level && n < limit) begin
			tick();
			n++;
		end
		if (sig_value(sel) !== level)
			note_timeout($sformatf("%s to reach %0b", sig_name(sel), level));
	endtask

	////////////////////////////////////////////////////////////
	// Whole VGA frame, vsync start to vsync start
	////////////////////////////////////////////////////////////

	task automatic check_frame();
		int   n;
		int   cyc;
		int   run;
		int   lines;
		logic seen_idle;
		logic prev_de;
		logic neg;
		neg = sync_active_low(4'h0);
		wait_for(SIG_VS, !neg, 600000, n);
		cyc = 0;
		run = 0;
		lines = 0;
		seen_idle = 1'b0;
		prev_de = de;
		while (!(seen_idle && vsync === !neg) && cyc < 1000000) begin
			tick();
			cyc++;
			if (vsync === neg)
				seen_idle = 1'b1;
			if (de === 1'b1) begin
				if (prev_de !== 1'b1) begin // Line just started, counters 2 ahead
					check_count(hcount, 11'd2, "hcount at de start");
					check_count(vcount, video_mode_pkg::coord_t'(lines), "vcount at de start");
				end
				run++;
			end else if (prev_de) begin // Line just ended
				lines++;
				check_count(video_mode_pkg::coord_t'(run), video_mode_pkg::coord_t'(h_part(4'h0, 0)),
					"de run in frame");
				run = 0;
			end
			prev_de = de;
		end
		if (cyc >= 1000000)
			note_timeout("the next vsync pulse");
		check_cycles(cyc, line_length(4'h0) * frame_lines(4'h0), "vsync period");
		check_count(video_mode_pkg::coord_t'(lines), video_mode_pkg::coord_t'(v_part(4'h0, 0)),
			"de lines per frame");
	endtask

	////////////////////////////////////////////////////////////
	// One format: go, hold, then line timing
	////////////////////////////////////////////////////////////

	task automatic run_format(input logic [3:0] code);
		int   n;
		int   w;
		int   go_before;
		logic neg;
		neg = sync_active_low(code);
		go_before = go_cnt;
		exp_code = code;
		sw = code;
		wait_for(SIG_GO, 1'b1, 200, n);
		repeat (4) tick(); // Raster now held in restart
		check_level(hsync, neg, "hsync idle level");
		check_level(vsync, neg, "vsync idle level");
		check_level(de, 1'b0, "de during restart");
		check_count(hcount, 11'd0, "hcount during restart");
		check_count(vcount, 11'd0, "vcount during restart");
		wait_for(SIG_HS, !neg, 4000, n);
		wait_for(SIG_HS, neg, 4000, w);
		check_count(video_mode_pkg::coord_t'(w), video_mode_pkg::coord_t'(h_part(code, 2)),
			"hsync width");
		wait_for(SIG_HS, !neg, 4000, n);
		check_count(video_mode_pkg::coord_t'(w + n), video_mode_pkg::coord_t'(line_length(code)),
			"hsync period");
		repeat (2) begin
			wait_for(SIG_DE, 1'b1, 4000, n);
			wait_for(SIG_DE, 1'b0, 4000, w);
			check_count(video_mode_pkg::coord_t'(w), video_mode_pkg::coord_t'(h_part(code, 0)),
				"de run");
		end
		if (code == 4'h0)
			check_frame();
		check_cycles(go_cnt - go_before, 1, "prog_go pulses per change");
	endtask

	initial begin : watchdog
		int unsigned n;
		n = 0;
		while (!hung && n < MAX_CYCLES) begin
			@(posedge clk50m_bufg);
			n++;
		end
		if (hung)
			$display("Run stopped: a wait on the DUT timed out");
		else
			$display("Run stopped: cycle limit of %0d reached", MAX_CYCLES);
		report_counts();
		$display(">>> FAIL");
		$finish;
	end

	initial begin : stimulus
		logic [3:0]           order [7];
		logic [3:0]           tmp;
		logic [3:0]           glitch;
		int unsigned          seed;
		int                   i;
		int                   j;
		int                   n;
		int                   go_before;
		RSTBTN = 1'b1;
		sw = 4'b0000;
		exp_code = 4'h0;
		order = '{4'h0, 4'h1, 4'h2, 4'h3, 4'h8, 4'h9, 4'h5}; // 0101 is unlisted
		repeat (3) tick();
		RSTBTN = 1'b0;

		// Reset state and the first go
		check_fmt(fmt, video_mode_pkg::FMT_VGA, "fmt after reset");
		wait_for(SIG_GO, 1'b1, 10, n);
		repeat (30) begin
			tick();
			check_level(de, 1'b0, "de while held after reset");
		end
		check_cycles(go_cnt, 1, "prog_go pulses after reset");

		// Shuffle the formats, first one must differ from VGA
		seed = 35;
		for (i = 6; i > 0; i--) begin
			seed = lcg_next(seed);
			j = int'((seed >> 16) % (i + 1));
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		if (order[0] == 4'h0) begin
			order[0] = order[1];
			order[1] = 4'h0;
		end
		for (i = 0; i < 7; i++)
			run_format(order[i]);

		// Short bounce must be dropped
		glitch = order[6] ^ 4'b0100;
		go_before = go_cnt;
		sw = glitch;
		repeat (8) tick();
		sw = order[6];
		repeat (60) tick();
		check_cycles(go_cnt - go_before, 0, "prog_go after short pulse");
		check_fmt(fmt, video_mode_pkg::fmt_e'(order[6]), "fmt after short pulse");

		report_counts();
		if (err_cnt == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* video/raster_gen.sv */
`timescale 1ns/1ps

module raster_gen (
	input  logic                   clk50m_bufg,
	input  logic                   restart,  // Counters held at zero
	input  video_mode_pkg::coord_t h_sblnk,
	input  video_mode_pkg::coord_t h_ssync,
	input  video_mode_pkg::coord_t h_esync,
	input  video_mode_pkg::coord_t h_eblnk,
	input  video_mode_pkg::coord_t v_sblnk,
	input  video_mode_pkg::coord_t v_ssync,
	input  video_mode_pkg::coord_t v_esync,
	input  video_mode_pkg::coord_t v_eblnk,
	input  logic                   sync_neg, // Idle sync level
	output video_mode_pkg::coord_t hcount,
	output video_mode_pkg::coord_t vcount,
	output logic                   hsync,
	output logic                   vsync,
	output logic                   de
);

	logic h_last;   // Last pixel of the line
	logic v_last;   // Last line of the frame
	logic hblnk;
	logic vblnk;
	logic hsync_on; // Sync windows before polarity
	logic vsync_on;
	logic active;
	logic hsync_q;  // First output stage
	logic vsync_q;
	logic active_q;

	assign h_last = (hcount == h_eblnk);
	assign v_last = (vcount == v_eblnk);

	////////////////////////////////////////////////////////////
	// Pixel and line counters
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk50m_bufg) begin
		if (restart) begin
			hcount <= '0;
			vcount <= '0;
		end else if (h_last) begin
			hcount <= '0;
			if (v_last)
				vcount <= '0;            // Frame wrap
			else
				vcount <= vcount + 1'b1; // Next line
		end else begin
			hcount <= hcount + 1'b1;
		end
	end

	// Blank and sync windows
	assign hblnk    = (hcount > h_sblnk);
	assign vblnk    = (vcount > v_sblnk);
	assign hsync_on = (hcount > h_ssync) && (hcount <= h_esync);
	assign vsync_on = (vcount > v_ssync) && (vcount <= v_esync);
	assign active   = !restart && !hblnk && !vblnk; // Nothing shown while held

	////////////////////////////////////////////////////////////
	// Two register stages on sync and DE
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk50m_bufg) begin
		hsync_q  <= hsync_on ^ sync_neg; // Polarity applied here
		vsync_q  <= vsync_on ^ sync_neg;
		active_q <= active;
		hsync    <= hsync_q;
		vsync    <= vsync_q;
		de       <= active_q;
	end

	// Table keeps the sync pulse inside the blanking interval
	a_de_not_in_hsync: assert property (@(posedge clk50m_bufg) disable iff (restart)
		de |-> (hsync == $past(sync_neg, 2)));

endmodule

/* video/timing_table.sv */
`timescale 1ns/1ps

module timing_table (
	input  video_mode_pkg::fmt_e   fmt,
	output video_mode_pkg::coord_t h_sblnk, // Last active pixel
	output video_mode_pkg::coord_t h_ssync,
	output video_mode_pkg::coord_t h_esync,
	output video_mode_pkg::coord_t h_eblnk, // Last pixel of the line
	output video_mode_pkg::coord_t v_sblnk, // Last active line
	output video_mode_pkg::coord_t v_ssync,
	output video_mode_pkg::coord_t v_esync,
	output video_mode_pkg::coord_t v_eblnk, // Last line of the frame
	output logic                   sync_neg // Syncs active low
);

	video_mode_pkg::coord_t h_par [4]; // Active, front porch, sync, back porch
	video_mode_pkg::coord_t v_par [4];
	logic                   neg;

	// Pick the timing set
	always_comb begin
		case (fmt)
			video_mode_pkg::FMT_VGA: begin
				h_par = video_mode_pkg::VGA_H;
				v_par = video_mode_pkg::VGA_V;
				neg   = video_mode_pkg::NEG_VGA;
			end
			video_mode_pkg::FMT_SVGA: begin
				h_par = video_mode_pkg::SVGA_H;
				v_par = video_mode_pkg::SVGA_V;
				neg   = video_mode_pkg::NEG_SVGA;
			end
			video_mode_pkg::FMT_XGA: begin
				h_par = video_mode_pkg::XGA_H;
				v_par = video_mode_pkg::XGA_V;
				neg   = video_mode_pkg::NEG_XGA;
			end
			video_mode_pkg::FMT_SXGA: begin
				h_par = video_mode_pkg::SXGA_H;
				v_par = video_mode_pkg::SXGA_V;
				neg   = video_mode_pkg::NEG_SXGA;
			end
			video_mode_pkg::FMT_CAMERA: begin
				h_par = video_mode_pkg::CAMERA_H;
				v_par = video_mode_pkg::CAMERA_V;
				neg   = video_mode_pkg::NEG_CAMERA;
			end
			default: begin // 720p, also any unlisted code
				h_par = video_mode_pkg::HD720P_H;
				v_par = video_mode_pkg::HD720P_V;
				neg   = video_mode_pkg::NEG_HD720P;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// Boundaries, each one built on the previous
	////////////////////////////////////////////////////////////

	assign h_sblnk = h_par[video_mode_pkg::T_ACT] - 11'd1;
	assign h_ssync = h_sblnk + h_par[video_mode_pkg::T_FP];
	assign h_esync = h_ssync + h_par[video_mode_pkg::T_SYNC];
	assign h_eblnk = h_esync + h_par[video_mode_pkg::T_BP];

	assign v_sblnk = v_par[video_mode_pkg::T_ACT] - 11'd1;
	assign v_ssync = v_sblnk + v_par[video_mode_pkg::T_FP];
	assign v_esync = v_ssync + v_par[video_mode_pkg::T_SYNC];
	assign v_eblnk = v_esync + v_par[video_mode_pkg::T_BP];

	assign sync_neg = neg;

endmodule
